/* include/mbist_settings.svh */
`ifndef MBIST_SETTINGS_SVH
`define MBIST_SETTINGS_SVH

// geometry of the 128 x 8 SRAM
`define MBIST_ADDR_W 7
`define MBIST_DATA_W 8

// number of words in the SRAM
`define MBIST_WORDS 128

// max reads in flight and depth of the expect queue
`define MBIST_CREDITS 4

// saturating mismatch counter
`define MBIST_FAILCNT_W 8

`endif

/* rtl/mbistPkg.sv */
`include "mbist_settings.svh"

package mbistPkg;

    typedef logic [`MBIST_ADDR_W-1:0] addrT;
    typedef logic [`MBIST_DATA_W-1:0] dataT;
    typedef logic [`MBIST_FAILCNT_W-1:0] failCntT;
    typedef logic [$clog2(`MBIST_CREDITS + 1)-1:0] creditT;   // must hold the full count

    typedef enum logic {
        ALGO_MSCAN,
        ALGO_MARCHC
    } algoT;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_DRAIN,
        SEQ_DONE
    } seqStateT;

    typedef struct packed {
        logic valid;
        logic write;
        addrT addr;
        dataT data;
    } memReqT;

    typedef struct packed {
        logic valid;
        dataT data;
    } memRspT;

    // expected word for one outstanding read
    typedef struct packed {
        addrT addr;
        dataT data;
    } expectT;

    typedef struct packed {
        logic    busy;
        logic    done;
        logic    fail;
        failCntT failCount;
        addrT    failAddr;
    } bistStatusT;

endpackage

/* rtl/marchSequencer.sv */
`timescale 1ns/1ps
`include "mbist_settings.svh"

module marchSequencer (
    input  logic              CLK,
    input  logic              nRESET,
    input  logic              start,
    input  mbistPkg::algoT    algo,
    input  logic              creditReturn,
    input  logic              queueEmpty,
    output mbistPkg::memReqT  memReq,
    output logic              expPush,
    output mbistPkg::expectT  expData,
    output logic              busy,
    output logic              done
);
    import mbistPkg::*;

    // one march element; a pair is read then write at the same address
    typedef struct packed {
        logic doRead;
        logic doWrite;
        logic readOne;
        logic writeOne;
        logic down;
        logic last;
    } elemT;

    localparam addrT LAST_ADDR = addrT'(`MBIST_WORDS - 1);
    localparam creditT FULL_CREDITS = creditT'(`MBIST_CREDITS);

    seqStateT   state;
    algoT       algoReg;
    logic [2:0] elemIdx;
    logic       phase;      // set while on the write half of a pair
    addrT       addr;
    creditT     credits;

    elemT       cur;
    elemT       nxt;
    logic       isRead;
    logic       issue;
    logic       opDone;
    logic       addrDone;
    dataT       readWord;
    dataT       writeWord;

    function automatic elemT elemInfo(algoT a, logic [2:0] idx);
        elemT e;
        e = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        if (a == ALGO_MSCAN) begin
            case (idx)
                3'd0: e = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};   // w0 up
                3'd1: e = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};   // r0 up
                3'd2: e = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};   // w1 up
                3'd3: e = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};   // r1 up
                default: e.last = 1'b1;
            endcase
        end else begin
            case (idx)
                3'd0: e = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};   // w0 up
                3'd1: e = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};   // r0,w1 up
                3'd2: e = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};   // r1,w0 up
                3'd3: e = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};   // r0,w1 down
                3'd4: e = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};   // r1,w0 down
                3'd5: e = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};   // r0 up
                default: e.last = 1'b1;
            endcase
        end
        return e;
    endfunction

    always_comb begin
        cur = elemInfo(algoReg, elemIdx);
        nxt = elemInfo(algoReg, elemIdx + 3'd1);
    end

    assign isRead    = cur.doRead && !phase;
    assign issue     = (state == SEQ_RUN) && (!isRead || credits != '0);   // reads need a credit
    assign opDone    = !(cur.doRead && cur.doWrite && !phase);
    assign addrDone  = (addr == (cur.down ? addrT'(0) : LAST_ADDR));
    assign readWord  = cur.readOne ? '1 : '0;
    assign writeWord = cur.writeOne ? '1 : '0;

    always_comb begin
        memReq.valid = issue;
        memReq.write = !isRead;
        memReq.addr  = addr;
        memReq.data  = isRead ? readWord : writeWord;
    end

    assign expPush      = issue && isRead;
    assign expData.addr = addr;
    assign expData.data = readWord;

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            credits <= FULL_CREDITS;
        end else begin
            case ({expPush, creditReturn})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;     // take and return cancel
            endcase
        end
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            state   <= SEQ_IDLE;
            algoReg <= ALGO_MSCAN;
            elemIdx <= '0;
            phase   <= 1'b0;
            addr    <= '0;
        end else begin
            case (state)
                SEQ_IDLE, SEQ_DONE: begin
                    if (start) begin
                        state   <= SEQ_RUN;
                        algoReg <= algo;
                        elemIdx <= '0;
                        phase   <= 1'b0;
                        addr    <= '0;               // first element always ascends
                    end
                end
                SEQ_RUN: begin
                    if (issue) begin
                        if (!opDone) begin
                            phase <= 1'b1;
                        end else begin
                            phase <= 1'b0;
                            if (addrDone) begin
                                if (cur.last) begin
                                    state <= SEQ_DRAIN;
                                end else begin
                                    elemIdx <= elemIdx + 3'd1;
                                    addr    <= nxt.down ? LAST_ADDR : '0;
                                end
                            end else if (cur.down) begin
                                addr <= addr - 1'b1;
                            end else begin
                                addr <= addr + 1'b1;
                            end
                        end
                    end
                end
                SEQ_DRAIN: begin
                    // all reads answered and checked
                    if (credits == FULL_CREDITS && queueEmpty) begin
                        state <= SEQ_DONE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign busy = (state == SEQ_RUN) || (state == SEQ_DRAIN);
    assign done = (state == SEQ_DONE);

endmodule

/* rtl/expectQueue.sv */
`timescale 1ns/1ps
`include "mbist_settings.svh"

module expectQueue (
    input  logic              CLK,
    input  logic              nRESET,
    input  logic              push,
    input  mbistPkg::expectT  pushData,
    input  logic              pop,
    input  logic              clear,
    output mbistPkg::expectT  head,
    output logic              empty
);
    import mbistPkg::*;

    localparam int DEPTH = `MBIST_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);

    expectT           mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    creditT           count;     // depth equals the credit count

    function automatic logic [PTR_W-1:0] bump(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (clear) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= bump(wrPtr);
            end
            if (pop) begin
                rdPtr <= bump(rdPtr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head  = mem[rdPtr];
    assign empty = (count == '0);

endmodule

/* rtl/responseChecker.sv */
`timescale 1ns/1ps

module responseChecker (
    input  logic              CLK,
    input  logic              nRESET,
    input  logic              clear,
    input  mbistPkg::memRspT  memRsp,
    input  mbistPkg::expectT  head,
    output logic              pop,
    output logic              fail,
    output mbistPkg::failCntT failCount,
    output mbistPkg::addrT    failAddr
);
    import mbistPkg::*;

    localparam failCntT CNT_MAX = '1;

    logic mismatch;

    // responses come back in order, so the head is always the match
    assign pop      = memRsp.valid;
    assign mismatch = memRsp.valid && (memRsp.data != head.data);

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            fail      <= 1'b0;
            failCount <= '0;
            failAddr  <= '0;
        end else if (clear) begin
            fail      <= 1'b0;
            failCount <= '0;
            failAddr  <= '0;
        end else if (mismatch) begin
            fail <= 1'b1;
            if (failCount != CNT_MAX) begin
                failCount <= failCount + 1'b1;   // saturates
            end
            if (!fail) begin
                failAddr <= head.addr;           // first failure only
            end
        end
    end

endmodule

/* rtl/mbistTop.sv */
`timescale 1ns/1ps

module mbistTop (
    input  logic                 CLK,
    input  logic                 nRESET,
    input  logic                 start,
    input  mbistPkg::algoT       algo,
    input  mbistPkg::memRspT     memRsp,
    input  logic                 creditReturn,
    output mbistPkg::memReqT     memReq,
    output mbistPkg::bistStatusT status
);
    import mbistPkg::*;

    logic    expPush;
    logic    pop;
    logic    queueEmpty;
    logic    clear;
    logic    busy;
    logic    done;
    logic    fail;
    expectT  expData;
    expectT  queueHead;
    failCntT failCount;
    addrT    failAddr;

    // start only takes effect when the engine is idle or done
    assign clear = start && !busy;

    marchSequencer i_marchSequencer (
        .CLK          (CLK),
        .nRESET       (nRESET),
        .start        (start),
        .algo         (algo),
        .creditReturn (creditReturn),
        .queueEmpty   (queueEmpty),
        .memReq       (memReq),
        .expPush      (expPush),
        .expData      (expData),
        .busy         (busy),
        .done         (done)
    );

    expectQueue i_expectQueue (
        .CLK      (CLK),
        .nRESET   (nRESET),
        .push     (expPush),
        .pushData (expData),
        .pop      (pop),
        .clear    (clear),
        .head     (queueHead),
        .empty    (queueEmpty)
    );

    responseChecker i_responseChecker (
        .CLK       (CLK),
        .nRESET    (nRESET),
        .clear     (clear),
        .memRsp    (memRsp),
        .head      (queueHead),
        .pop       (pop),
        .fail      (fail),
        .failCount (failCount),
        .failAddr  (failAddr)
    );

    always_comb begin
        status.busy      = busy;
        status.done      = done;
        status.fail      = fail;
        status.failCount = failCount;
        status.failAddr  = failAddr;
    end

endmodule

/* testbench/memModel.sv */
`timescale 1ns/1ps
`include "mbist_settings.svh"

module memModel (
    input  logic             CLK,
    input  logic             nRESET,
    input  mbistPkg::memReqT memReq,
    input  logic             faultEn,
    input  mbistPkg::addrT   faultAddr,
    input  logic [2:0]       faultBit,
    input  logic             faultVal,
    output mbistPkg::memRspT memRsp,
    output logic             creditReturn,
    output int               outstanding
);
    import mbistPkg::*;

    dataT   mem [`MBIST_WORDS];
    dataT   rspData [$];
    longint rspDue [$];
    longint cycle = 0;
    longint lastDue = 0;

    initial begin
        memRsp       = '0;
        creditReturn = 1'b0;
        void'($urandom(32'h2b7539f2));
    end

    // requests are stable on the falling edge and commit on the next rising edge
    always @(negedge CLK) begin
        dataT   word;
        longint due;
        cycle++;
        if (!nRESET) begin
            for (int i = 0; i < `MBIST_WORDS; i++) begin
                mem[i] = dataT'(i * 37 + 11);    // power-up contents
            end
            memRsp       = '0;
            creditReturn = 1'b0;
            outstanding  = 0;
        end else begin
            if (memReq.valid && memReq.write) begin
                mem[memReq.addr] = memReq.data;
            end else if (memReq.valid) begin
                word = mem[memReq.addr];
                if (faultEn && memReq.addr == faultAddr) begin
                    word[faultBit] = faultVal;   // stuck-at cell
                end
                due = cycle + 1 + ($urandom % 4);
                if (due <= lastDue) begin
                    due = lastDue + 1;           // answers stay in order
                end
                lastDue = due;
                rspData.push_back(word);
                rspDue.push_back(due);
                outstanding = outstanding + 1;
            end
            if (rspDue.size() != 0 && rspDue[0] <= cycle) begin
                memRsp.valid = 1'b1;
                memRsp.data  = rspData.pop_front();
                creditReturn = 1'b1;             // credit rides with the data
                void'(rspDue.pop_front());
                outstanding = outstanding - 1;
            end else begin
                memRsp       = '0;
                creditReturn = 1'b0;
            end
        end
    end

endmodule

/* testbench/tbMbist.sv */
`timescale 1ns/1ps
`include "mbist_settings.svh"

module tbMbist;
    import mbistPkg::*;

    // one line of the stimulus file
    typedef struct packed {
        logic       algoSel;
        logic       faultEn;
        addrT       faultAddr;
        logic [2:0] faultBit;
        logic       faultVal;
        logic       expFail;
        failCntT    expCount;
        addrT       expAddr;
    } testT;

    logic       CLK;
    logic       nRESET;
    logic       start;
    algoT       algo;
    memReqT     memReq;
    memRspT     memRsp;
    logic       creditReturn;
    bistStatusT status;
    logic       faultEn;
    addrT       faultAddr;
    logic [2:0] faultBit;
    logic       faultVal;
    int         outstanding;

    testT tests [$];
    int   valueErrors = 0;
    int   otherErrors = 0;
    int   peakReads = 0;
    int   cycles = 0;
    int   cycleLimit = 0;

    mbistTop i_mbistTop (
        .CLK          (CLK),
        .nRESET       (nRESET),
        .start        (start),
        .algo         (algo),
        .memRsp       (memRsp),
        .creditReturn (creditReturn),
        .memReq       (memReq),
        .status       (status)
    );

    memModel i_memModel (
        .CLK          (CLK),
        .nRESET       (nRESET),
        .memReq       (memReq),
        .faultEn      (faultEn),
        .faultAddr    (faultAddr),
        .faultBit     (faultBit),
        .faultVal     (faultVal),
        .memRsp       (memRsp),
        .creditReturn (creditReturn),
        .outstanding  (outstanding)
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;     // 8 ns period

    always @(posedge CLK) begin
        cycles++;
        if (outstanding > `MBIST_CREDITS) begin
            $display("%0t: %0d reads in flight at the memory, above the credit count",
                     $time, outstanding);
            otherErrors++;
        end
        if (outstanding > peakReads) peakReads = outstanding;
        if (cycleLimit != 0 && cycles > cycleLimit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("errors: %0d value, %0d other", valueErrors, otherErrors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
        valueErrors++;
        $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic checkIdleOutputs();
        if (memReq.valid !== 1'b0) reportMismatch("memReq.valid", 0, memReq.valid);
        if (status.busy !== 1'b0) reportMismatch("status.busy", 0, status.busy);
        if (status.done !== 1'b0) reportMismatch("status.done", 0, status.done);
        if (status.fail !== 1'b0) reportMismatch("status.fail", 0, status.fail);
    endtask

    task automatic loadTests();
        int    fd;
        int    f [8];
        string line;
        testT  t;
        fd = $fopen("testbench/mbist_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/mbist_stim.txt");
            otherErrors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] == "#") continue;   // column notes
            if ($sscanf(line, "%d %d %d %d %d %d %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]) == 8) begin
                t = '{f[0][0], f[1][0], addrT'(f[2]), 3'(f[3]), f[4][0], f[5][0],
                      failCntT'(f[6]), addrT'(f[7])};
                tests.push_back(t);
            end
        end
        $fclose(fd);
    endtask

    task automatic runTest(testT t, int idx);
        @(negedge CLK);
        faultEn   = t.faultEn;
        faultAddr = t.faultAddr;
        faultBit  = t.faultBit;
        faultVal  = t.faultVal;
        algo      = algoT'(t.algoSel);
        start     = 1'b1;
        @(negedge CLK);
        start = 1'b0;
        // previous result must be gone once start is taken
        if (status.busy !== 1'b1) reportMismatch("status.busy", 1, status.busy);
        if (status.done !== 1'b0) reportMismatch("status.done", 0, status.done);
        if (status.fail !== 1'b0) reportMismatch("status.fail", 0, status.fail);
        if (status.failCount !== '0) reportMismatch("status.failCount", 0, status.failCount);
        while (status.done !== 1'b1) @(negedge CLK);
        if (status.busy !== 1'b0) reportMismatch("status.busy", 0, status.busy);
        if (status.fail !== t.expFail) reportMismatch("status.fail", t.expFail, status.fail);
        if (status.failCount !== t.expCount)
            reportMismatch("status.failCount", t.expCount, status.failCount);
        if (status.failAddr !== t.expAddr)
            reportMismatch("status.failAddr", t.expAddr, status.failAddr);
        $display("test %0d: %s fault %0b count %0d", idx, algo.name(), t.faultEn,
                 status.failCount);
    endtask

    initial begin
        nRESET    = 1'b0;
        start     = 1'b0;
        algo      = ALGO_MSCAN;
        faultEn   = 1'b0;
        faultAddr = '0;
        faultBit  = '0;
        faultVal  = 1'b0;
        loadTests();
        if (tests.size() == 0) begin
            $display("no tests found in the stimulus file");
            otherErrors++;
        end
        foreach (tests[i]) begin
            // MSCAN takes 4N operations and March C- 10N
            cycleLimit += (tests[i].algoSel ? 10 : 4) * `MBIST_WORDS * 5 + 100;
        end
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        checkIdleOutputs();
        nRESET = 1'b1;
        @(negedge CLK);
        checkIdleOutputs();
        foreach (tests[i]) runTest(tests[i], i);
        if (peakReads < `MBIST_CREDITS) begin
            $display("reads were never pipelined up to the credit limit");
            otherErrors++;
        end
        $display("errors: %0d value, %0d other, peak reads in flight %0d",
                 valueErrors, otherErrors, peakReads);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* testbench/mbist_stim.txt */
# algo (0 MSCAN, 1 March C-), faultEn, faultAddr, faultBit, stuckVal,
# expected fail, expected failCount, expected failAddr; all decimal
0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0
0 1 37 3 0 1 1 37
0 1 90 6 1 1 1 90
1 1 0 0 1 1 3 0
1 1 127 7 0 1 2 127
0 0 0 0 0 0 0 0
1 1 127 2 1 1 3 127
1 1 0 5 0 1 2 0
1 0 0 0 0 0 0 0
1 1 64 4 1 1 3 64
1 1 13 1 0 1 2 13
0 1 0 0 1 1 1 0
0 1 127 1 0 1 1 127
1 0 0 0 0 0 0 0

/* vlog.f */
+incdir+include
rtl/mbistPkg.sv
rtl/marchSequencer.sv
rtl/expectQueue.sv
rtl/responseChecker.sv
rtl/mbistTop.sv
testbench/memModel.sv
testbench/tbMbist.sv
